/* Bender.yml */
package:
  name: mips_core

sources:
  - hw/mips_pkg.sv
  - hw/pipeline_reg.sv
  - hw/decoder.sv
  - hw/regfile.sv
  - hw/operand_forward.sv
  - hw/alu.sv
  - hw/mips_core.sv
  - target: simulation
    files:
      - tb/tb_mips_core.sv

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   result
);

    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or: result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            // shifts act on the rt operand
            alu_sll: result = b << shamt;
            alu_srl: result = b >> shamt;
            alu_sra: result = $signed(b) >>> shamt;
            alu_lui: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  mips_pkg::word_t     instr,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::reg_addr_t dest,
    output mips_pkg::word_t     imm,
    output logic [4:0]          shamt,
    output mips_pkg::alu_op_e   alu_op,
    output logic                b_is_imm,
    output logic                mem_read,
    output logic                mem_write,
    output logic                reg_write,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_jump,
    output logic                uses_rs,
    output logic                uses_rt
);

    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic sign_ext;
    logic dest_is_rd;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign shamt = instr[10:6];
    assign imm = sign_ext ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
    assign dest = dest_is_rd ? instr[15:11] : instr[20:16];

    always_comb begin
        // unknown encodings fall out as a nop
        alu_op = alu_add;
        sign_ext = 1'b1;
        dest_is_rd = 1'b0;
        b_is_imm = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        is_jump = 1'b0;
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        case (opcode)
            op_special: begin
                dest_is_rd = 1'b1;
                reg_write = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    funct_addu: alu_op = alu_add;
                    funct_subu: alu_op = alu_sub;
                    funct_and: alu_op = alu_and;
                    funct_or: alu_op = alu_or;
                    funct_xor: alu_op = alu_xor;
                    funct_slt: alu_op = alu_slt;
                    funct_sltu: alu_op = alu_sltu;
                    funct_sll: begin
                        alu_op = alu_sll;
                        uses_rs = 1'b0;
                    end
                    funct_srl: begin
                        alu_op = alu_srl;
                        uses_rs = 1'b0;
                    end
                    funct_sra: begin
                        alu_op = alu_sra;
                        uses_rs = 1'b0;
                    end
                    default: begin
                        reg_write = 1'b0;
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            op_addiu, op_andi, op_ori, op_lui, op_lw: begin
                b_is_imm = 1'b1;
                reg_write = 1'b1;
                uses_rs = (opcode != op_lui);
                sign_ext = (opcode == op_addiu) || (opcode == op_lw);
                mem_read = (opcode == op_lw);
                if (opcode == op_andi) begin
                    alu_op = alu_and;
                end else if (opcode == op_ori) begin
                    alu_op = alu_or;
                end else if (opcode == op_lui) begin
                    alu_op = alu_lui;
                end
            end
            op_sw: begin
                b_is_imm = 1'b1;
                mem_write = 1'b1;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            op_beq, op_bne: begin
                is_beq = (opcode == op_beq);
                is_bne = (opcode == op_bne);
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            op_j: is_jump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_core #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                reset,
    output logic                inst_sram_en,
    output logic [3:0]          inst_sram_wen,
    output mips_pkg::word_t     inst_sram_addr,
    output mips_pkg::word_t     inst_sram_wdata,
    input  mips_pkg::word_t     inst_sram_rdata,
    output logic                data_sram_en,
    output logic [3:0]          data_sram_wen,
    output mips_pkg::word_t     data_sram_addr,
    output mips_pkg::word_t     data_sram_wdata,
    input  mips_pkg::word_t     data_sram_rdata,
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);

    import mips_pkg::*;

    word_t pc_q;
    word_t pc_next;
    word_t delay_pc;
    logic fetch_valid_q;
    if_id_t if_in;
    if_id_t id_q;
    id_ex_t id_out;
    id_ex_t ex_q;
    ex_mem_t ex_out;
    ex_mem_t mem_q;
    mem_wb_t mem_out;
    mem_wb_t wb_q;
    logic id_valid;
    logic ex_valid;
    logic mem_valid;
    logic wb_valid;
    logic if_id_allow;
    logic id_ex_allow;
    logic ex_mem_allow;
    logic mem_wb_allow;
    logic load_use_stall;

    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    word_t imm;
    logic [4:0] shamt;
    alu_op_e alu_op;
    logic b_is_imm;
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic is_beq;
    logic is_bne;
    logic is_jump;
    logic uses_rs;
    logic uses_rt;
    word_t rf_rs_data;
    word_t rf_rt_data;
    word_t rs_data;
    word_t rt_data;
    logic branch_taken;
    word_t alu_b;
    word_t alu_result;
    word_t mem_result;
    logic wb_wen;

    // fetch: word for pc_q arrives one cycle after its address
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= reset_pc - 32'd4;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q <= pc_next;
            fetch_valid_q <= 1'b1;
        end
    end

    // targets are relative to the delay slot
    assign delay_pc = id_q.pc + 32'd4;
    assign branch_taken = id_valid &&
                          ((is_beq && rs_data == rt_data) || (is_bne && rs_data != rt_data));

    always_comb begin
        if (!if_id_allow) begin
            pc_next = pc_q;
        end else if (id_valid && is_jump) begin
            pc_next = {delay_pc[31:28], id_q.instr[25:0], 2'b00};
        end else if (branch_taken) begin
            pc_next = delay_pc + {imm[29:0], 2'b00};
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    assign inst_sram_en = 1'b1;
    assign inst_sram_wen = 4'b0000;
    assign inst_sram_addr = pc_next;
    assign inst_sram_wdata = '0;
    assign if_in = '{pc: pc_q, instr: inst_sram_rdata};

    pipeline_reg #(.payload_t(if_id_t)) i_if_id (
        .clk(clk),
        .reset(reset),
        .stall(load_use_stall),
        .valid_in(fetch_valid_q),
        .allow_in(if_id_allow),
        .valid_out(id_valid),
        .allow_out(id_ex_allow),
        .in_data(if_in),
        .out_data(id_q)
    );

    decoder i_decoder (
        .instr(id_q.instr),
        .rs(rs),
        .rt(rt),
        .dest(dest),
        .imm(imm),
        .shamt(shamt),
        .alu_op(alu_op),
        .b_is_imm(b_is_imm),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .reg_write(reg_write),
        .is_beq(is_beq),
        .is_bne(is_bne),
        .is_jump(is_jump),
        .uses_rs(uses_rs),
        .uses_rt(uses_rt)
    );

    regfile i_regfile (
        .clk(clk),
        .raddr1(rs),
        .raddr2(rt),
        .rdata1(rf_rs_data),
        .rdata2(rf_rt_data),
        .wen(wb_wen),
        .waddr(wb_q.dest),
        .wdata(wb_q.wdata)
    );

    operand_forward i_operand_forward (
        .rs(rs),
        .rt(rt),
        .uses_rs(uses_rs),
        .uses_rt(uses_rt),
        .ex_valid(ex_valid),
        .ex_reg_write(ex_q.reg_write),
        .ex_mem_read(ex_q.mem_read),
        .ex_dest(ex_q.dest),
        .ex_result(alu_result),
        .mem_valid(mem_valid),
        .mem_reg_write(mem_q.reg_write),
        .mem_dest(mem_q.dest),
        .mem_result(mem_result),
        .wb_valid(wb_valid),
        .wb_reg_write(wb_q.reg_write),
        .wb_dest(wb_q.dest),
        .wb_result(wb_q.wdata),
        .rf_rs_data(rf_rs_data),
        .rf_rt_data(rf_rt_data),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .load_use_stall(load_use_stall)
    );

    assign id_out = '{
        pc: id_q.pc,
        rs_val: rs_data,
        rt_val: rt_data,
        imm: imm,
        shamt: shamt,
        alu_op: alu_op,
        b_is_imm: b_is_imm,
        mem_read: mem_read,
        mem_write: mem_write,
        reg_write: reg_write,
        dest: dest
    };

    pipeline_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk),
        .reset(reset),
        .stall(1'b0),
        .valid_in(id_valid),
        .allow_in(id_ex_allow),
        .valid_out(ex_valid),
        .allow_out(ex_mem_allow),
        .in_data(id_out),
        .out_data(ex_q)
    );

    // execute
    assign alu_b = ex_q.b_is_imm ? ex_q.imm : ex_q.rt_val;

    alu i_alu (
        .op(ex_q.alu_op),
        .a(ex_q.rs_val),
        .b(alu_b),
        .shamt(ex_q.shamt),
        .result(alu_result)
    );

    assign data_sram_en = ex_valid && (ex_q.mem_read || ex_q.mem_write);
    assign data_sram_wen = {4{ex_valid && ex_q.mem_write}};
    assign data_sram_addr = alu_result;
    assign data_sram_wdata = ex_q.rt_val;
    assign ex_out = '{
        pc: ex_q.pc,
        result: alu_result,
        mem_read: ex_q.mem_read,
        reg_write: ex_q.reg_write,
        dest: ex_q.dest
    };

    pipeline_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk(clk),
        .reset(reset),
        .stall(1'b0),
        .valid_in(ex_valid),
        .allow_in(ex_mem_allow),
        .valid_out(mem_valid),
        .allow_out(mem_wb_allow),
        .in_data(ex_out),
        .out_data(mem_q)
    );

    // memory: load data shows up here
    assign mem_result = mem_q.mem_read ? data_sram_rdata : mem_q.result;
    assign mem_out = '{
        pc: mem_q.pc,
        wdata: mem_result,
        reg_write: mem_q.reg_write,
        dest: mem_q.dest
    };

    pipeline_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk(clk),
        .reset(reset),
        .stall(1'b0),
        .valid_in(mem_valid),
        .allow_in(mem_wb_allow),
        .valid_out(wb_valid),
        .allow_out(1'b1),
        .in_data(mem_out),
        .out_data(wb_q)
    );

    // writeback, r0 writes still show on the trace
    assign wb_wen = wb_valid && wb_q.reg_write;
    assign debug_wb_pc = wb_q.pc;
    assign debug_wb_rf_wen = {4{wb_wen}};
    assign debug_wb_rf_wnum = wb_q.dest;
    assign debug_wb_rf_wdata = wb_q.wdata;

    no_store_without_valid_ex: assert property (
        @(posedge clk) disable iff (reset)
        !ex_valid |-> (data_sram_wen == 4'b0000)
    );

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_sltu, alu_sll,
        alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j = 6'h02;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_andi = 6'h0c;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_lui = 6'h0f;
    localparam logic [5:0] op_lw = 6'h23;
    localparam logic [5:0] op_sw = 6'h2b;

    // special funct field
    localparam logic [5:0] funct_sll = 6'h00;
    localparam logic [5:0] funct_srl = 6'h02;
    localparam logic [5:0] funct_sra = 6'h03;
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or = 6'h25;
    localparam logic [5:0] funct_xor = 6'h26;
    localparam logic [5:0] funct_slt = 6'h2a;
    localparam logic [5:0] funct_sltu = 6'h2b;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        word_t rs_val;
        word_t rt_val;
        word_t imm;
        logic [4:0] shamt;
        alu_op_e alu_op;
        logic b_is_imm;
        logic mem_read;
        logic mem_write;
        logic reg_write;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        word_t result;
        logic mem_read;
        logic reg_write;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        word_t pc;
        word_t wdata;
        logic reg_write;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

/* hw/operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                uses_rs,
    input  logic                uses_rt,
    input  logic                ex_valid,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::word_t     ex_result,
    input  logic                mem_valid,
    input  logic                mem_reg_write,
    input  mips_pkg::reg_addr_t mem_dest,
    input  mips_pkg::word_t     mem_result,
    input  logic                wb_valid,
    input  logic                wb_reg_write,
    input  mips_pkg::reg_addr_t wb_dest,
    input  mips_pkg::word_t     wb_result,
    input  mips_pkg::word_t     rf_rs_data,
    input  mips_pkg::word_t     rf_rt_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output logic                load_use_stall
);

    import mips_pkg::*;

    typedef enum logic [1:0] {from_rf, from_ex, from_mem, from_wb} fwd_src_e;

    fwd_src_e rs_src;
    fwd_src_e rt_src;
    logic ex_alu_wr;
    logic ex_load_wr;
    logic mem_wr;
    logic wb_wr;

    // writers to r0 never forward
    assign ex_alu_wr = ex_valid && ex_reg_write && !ex_mem_read && ex_dest != 5'd0;
    assign ex_load_wr = ex_valid && ex_reg_write && ex_mem_read && ex_dest != 5'd0;
    assign mem_wr = mem_valid && mem_reg_write && mem_dest != 5'd0;
    assign wb_wr = wb_valid && wb_reg_write && wb_dest != 5'd0;

    // youngest writer first
    function automatic fwd_src_e pick_src(input reg_addr_t r);
        if (ex_alu_wr && ex_dest == r) return from_ex;
        if (mem_wr && mem_dest == r) return from_mem;
        if (wb_wr && wb_dest == r) return from_wb;
        return from_rf;
    endfunction

    function automatic word_t fwd_data(input fwd_src_e src, input word_t rf_val);
        case (src)
            from_ex: return ex_result;
            from_mem: return mem_result;
            from_wb: return wb_result;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        rs_src = pick_src(rs);
        rt_src = pick_src(rt);
        rs_data = fwd_data(rs_src, rf_rs_data);
        rt_data = fwd_data(rt_src, rf_rt_data);
    end

    // load data is only there one stage later
    assign load_use_stall = ex_load_wr &&
                            ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));

    always_comb begin
        if (load_use_stall) begin
            assert final (rs_src != from_ex && rt_src != from_ex)
                else $error("load-use stall selected the execute result");
        end
    end

endmodule

`default_nettype wire

/* hw/pipeline_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     valid_in,
    output logic     allow_in,
    output logic     valid_out,
    input  logic     allow_out,
    input  payload_t in_data,
    output payload_t out_data
);

    logic full;
    payload_t data_q;

    // free slot, or the held item leaves this cycle
    assign allow_in = !full || (!stall && allow_out);
    assign valid_out = full && !stall;
    assign out_data = data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (allow_in) begin
            full <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && allow_in) begin
            data_q <= in_data;
        end
    end

    held_item_stable: assert property (
        @(posedge clk) disable iff (reset)
        (stall && full) |=> $stable(out_data)
    );

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                clk,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    output mips_pkg::word_t     rdata1,
    output mips_pkg::word_t     rdata2,
    input  logic                wen,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);

    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, same-cycle write bypasses the array
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (wen && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

/* sources.f */
hw/mips_pkg.sv
hw/pipeline_reg.sv
hw/decoder.sv
hw/regfile.sv
hw/operand_forward.sv
hw/alu.sv
hw/mips_core.sv
tb/tb_mips_core.sv

/* tb/core_patterns.txt */
# I <address> <instruction word>
# E <pc> <register number> <write data>, in retirement order
I bfc00000 3c018000
I bfc00004 342100f0
I bfc00008 2402fffd
I bfc0000c 00221821
I bfc00010 00612023
I bfc00014 00622824
I bfc00018 00853026
I bfc0001c 00c13825
I bfc00020 0026402a
I bfc00024 0026482b
I bfc00028 00025100
I bfc0002c 00015a02
I bfc00030 00016203
I bfc00034 30edff0f
I bfc00038 ac070010
I bfc0003c 8c0e0010
I bfc00040 01cd7821
I bfc00044 24000005
I bfc00048 000f8021
I bfc0004c 120f0002
I bfc00050 24110001
I bfc00054 24110002
I bfc00058 16310005
I bfc0005c 2632000a
I bfc00060 16400002
I bfc00064 24130007
I bfc00068 24130009
I bfc0006c 12600003
I bfc00070 26740001
I bfc00074 0bf00020
I bfc00078 24150021
I bfc0007c 24150031
I bfc00080 0bf00020
I bfc00084 14000000
E bfc00000 01 80000000
E bfc00004 01 800000f0
E bfc00008 02 fffffffd
E bfc0000c 03 800000ed
E bfc00010 04 fffffffd
E bfc00014 05 800000ed
E bfc00018 06 7fffff10
E bfc0001c 07 fffffff0
E bfc00020 08 00000001
E bfc00024 09 00000000
E bfc00028 0a ffffffd0
E bfc0002c 0b 00800000
E bfc00030 0c ff800000
E bfc00034 0d 0000ff00
E bfc0003c 0e fffffff0
E bfc00040 0f 0000fef0
E bfc00044 00 00000005
E bfc00048 10 0000fef0
E bfc00050 11 00000001
E bfc0005c 12 0000000b
E bfc00064 13 00000007
E bfc00070 14 00000008
E bfc00078 15 00000021

/* tb/tb_mips_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

    import mips_pkg::*;

    logic clk;
    logic reset;
    logic inst_sram_en;
    logic [3:0] inst_sram_wen;
    word_t inst_sram_addr;
    word_t inst_sram_wdata;
    word_t inst_sram_rdata;
    logic data_sram_en;
    logic [3:0] data_sram_wen;
    word_t data_sram_addr;
    word_t data_sram_wdata;
    word_t data_sram_rdata;
    word_t debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;
    word_t debug_wb_rf_wdata;

    // 1 KiB each, word addressed
    word_t imem [256];
    word_t dmem [256];

    word_t exp_pc [$];
    word_t exp_reg [$];
    word_t exp_data [$];
    int exp_idx;
    int errors;
    logic loaded;
    int watchdog_limit;

    mips_core i_mips_core (
        .clk(clk),
        .reset(reset),
        .inst_sram_en(inst_sram_en),
        .inst_sram_wen(inst_sram_wen),
        .inst_sram_addr(inst_sram_addr),
        .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata),
        .data_sram_en(data_sram_en),
        .data_sram_wen(data_sram_wen),
        .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int fd;
        int n;
        string line;
        word_t a;
        word_t b;
        word_t c;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        fd = $fopen("tb/core_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tb/core_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
                // program word
                if (line[0] == "I") begin
                    n = $sscanf(line, "I %h %h", a, b);
                    imem[a[9:2]] = b;
                end else if (line[0] == "E") begin
                    n = $sscanf(line, "E %h %h %h", a, b, c);
                    exp_pc.push_back(a);
                    exp_reg.push_back(b);
                    exp_data.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    // synchronous-read SRAM models
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int k = 0; k < 4; k++) begin
                if (data_sram_wen[k]) begin
                    dmem[data_sram_addr[9:2]][8*k +: 8] <= data_sram_wdata[8*k +: 8];
                end
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // trace checker, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_value("inst_sram_en", {31'b0, inst_sram_en}, 32'h1);
            check_value("inst_sram_wen", {28'b0, inst_sram_wen}, 32'h0);
            check_value("inst_sram_wdata", inst_sram_wdata, 32'h0);
            if (debug_wb_rf_wen != 4'h0) begin
                if (exp_idx >= exp_pc.size()) begin
                    $display("unexpected register write retired at pc %h", debug_wb_pc);
                    errors++;
                end else begin
                    check_value("debug_wb_pc", debug_wb_pc, exp_pc[exp_idx]);
                    check_value("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, exp_reg[exp_idx]);
                    check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[exp_idx]);
                    check_value("debug_wb_rf_wen", {28'b0, debug_wb_rf_wen}, 32'hf);
                    exp_idx++;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        watchdog_limit = 20 * exp_pc.size() + 100;
        repeat (watchdog_limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d expected trace entries never retired",
                 watchdog_limit, exp_pc.size() - exp_idx);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        errors = 0;
        exp_idx = 0;
        loaded = 1'b0;
        load_patterns();
        loaded = 1'b1;
        // reset takes hold at the first edge
        @(posedge clk);
        repeat (7) begin
            @(negedge clk);
            check_value("debug_wb_rf_wen", {28'b0, debug_wb_rf_wen}, 32'h0);
            check_value("data_sram_wen", {28'b0, data_sram_wen}, 32'h0);
        end
        @(posedge clk);
        reset <= 1'b0;
        // first fetch is still on its way
        @(negedge clk);
        check_value("debug_wb_rf_wen", {28'b0, debug_wb_rf_wen}, 32'h0);
        check_value("data_sram_wen", {28'b0, data_sram_wen}, 32'h0);
        while (exp_idx < exp_pc.size()) begin
            @(negedge clk);
        end
        // catch stray writes from the idle loop
        repeat (20) @(negedge clk);
        $display("%0d errors, %0d of %0d trace entries retired",
                 errors, exp_idx, exp_pc.size());
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
